//--- include/status_defs.svh
// ICE status block constants
// host register base, CPU read page, timer lengths, bus widths
// small timer values for simulation, hardware uses ms / s range

`ifndef STATUS_DEFS_SVH
`define STATUS_DEFS_SVH

//********************
// host side, registers at 0804_1000h
`define ST_HOST_BASE       20'h08041   // ice_addr[31:12]

// CPU side, reads at 0C040h / 0C042h
`define ST_CPU_PAGE        12'hC04     // ma[15:4]
`define ST_CPU_OFS_COUNT   4'h0        // buffered baseck count
`define ST_CPU_OFS_VALID   4'h2        // count valid flag in bit 0

//********************
// timers, in ck60mhz cycles
`define ST_HOLD_CYCLES     64          // wait/halt/stop held this long -> flagged
`define ST_CLKSTOP_CYCLES  32          // no cpumclk edge this long -> stopped
`define ST_METER_WIN_LOG2  8           // meter window = 256 cycles

//********************
// widths
`define ST_COUNT_W         16          // meter count
`define ST_ICE_W           32          // host bus
`define ST_MA_W            16          // CPU address

`endif

//--- hdl/status_pkg.sv
// shared types of the ICE status block
// host register index, clock meter state, meter count

`include "status_defs.svh"

package status_pkg;

	//********************
	// host register word index, taken from ice_addr[4:2]
	typedef enum logic [2:0] {
		reg_statedet = 3'd0,	// target status levels and flags
		reg_mcksel   = 3'd1,	// clock select, no longer present, reads 0
		reg_bckcycle = 3'd2,	// baseck count + valid
		reg_sys1     = 3'd3		// tvddsel
	} host_reg_e;

	//********************
	// clock meter state
	// first window after idle may start mid-window, so its count
	// is buffered but not yet flagged valid
	typedef enum logic [1:0] {
		meter_idle  = 2'd0,	// halted / stopped / after reset
		meter_first = 2'd1,	// first window running
		meter_valid = 2'd2	// buffered count trustworthy
	} meter_state_e;

	// baseck edge count
	typedef logic [`ST_COUNT_W-1:0] count_t;

endpackage

//--- hdl/activity_monitor.sv
// target activity monitor
// two-flop synchronizers for wait, halt, stop and cpumclk
// saturating hold timers on wait / halt / stop levels
// no-edge timer deciding whether the CPU main clock runs

`timescale 1ns/1ps
`include "status_defs.svh"

module activity_monitor (
	input  logic ck60mhz,
	input  logic sysrsoutb,
	input  logic waitexm,	// target wait level
	input  logic hltst,		// target halt level
	input  logic stpst,		// target stop level
	input  logic cpumclk,	// CPU main clock, async to ck60mhz
	output logic wait_long,
	output logic halt_long,
	output logic stop_long,
	output logic mclk_run,
	output logic halt_sync,	// to clock meter
	output logic stop_sync
);

	localparam int HOLD_W = $clog2(`ST_HOLD_CYCLES + 1);
	localparam int STOP_W = $clog2(`ST_CLKSTOP_CYCLES);

	logic [3:0]        sync1, sync2;	// {cpumclk, stop, halt, wait}
	logic              mclk_prev;		// for edge detect
	logic              mclk_edge;
	logic [2:0]        lvl;				// synchronized levels
	logic [2:0]        long_flag;
	logic [HOLD_W-1:0] hold_cnt [3];
	logic [STOP_W-1:0] stop_cnt;		// cycles since last cpumclk edge

	//********************
	// synchronizers
	always_ff @(posedge ck60mhz or negedge sysrsoutb) begin
		if (!sysrsoutb) begin
			sync1     <= '0;
			sync2     <= '0;
			mclk_prev <= 1'b0;
		end else begin
			sync1     <= {cpumclk, stpst, hltst, waitexm};
			sync2     <= sync1;
			mclk_prev <= sync2[3];
		end
	end

	assign lvl       = sync2[2:0];
	assign halt_sync = sync2[1];
	assign stop_sync = sync2[2];
	assign mclk_edge = sync2[3] ^ mclk_prev;	// either edge counts

	//********************
	// hold timers, one per level
	for (genvar i = 0; i < 3; i++) begin : g_hold
		always_ff @(posedge ck60mhz or negedge sysrsoutb) begin
			if (!sysrsoutb)
				hold_cnt[i] <= '0;
			else if (!lvl[i])
				hold_cnt[i] <= '0;	// level dropped, restart
			else if (hold_cnt[i] != HOLD_W'(`ST_HOLD_CYCLES))
				hold_cnt[i] <= hold_cnt[i] + 1'b1;	// saturate at hold time
		end
		assign long_flag[i] = (hold_cnt[i] == HOLD_W'(`ST_HOLD_CYCLES));
	end

	assign wait_long = long_flag[0];
	assign halt_long = long_flag[1];
	assign stop_long = long_flag[2];

	//********************
	// main clock stop detector
	always_ff @(posedge ck60mhz or negedge sysrsoutb) begin
		if (!sysrsoutb) begin
			stop_cnt <= STOP_W'(`ST_CLKSTOP_CYCLES - 1);	// start as stopped
			mclk_run <= 1'b0;
		end else if (mclk_edge) begin
			stop_cnt <= '0;
			mclk_run <= 1'b1;
		end else if (stop_cnt != STOP_W'(`ST_CLKSTOP_CYCLES - 1)) begin
			stop_cnt <= stop_cnt + 1'b1;
		end else begin
			mclk_run <= 1'b0;	// no edge for the whole stop window
		end
	end

endmodule

//--- hdl/clock_meter.sv
// baseck frequency meter
// baseck synchronizer and rising edge counter
// free running window counter, count buffer at window end
// valid state machine, cleared by halt / stop

`timescale 1ns/1ps
`include "status_defs.svh"

module clock_meter (
	input  logic               ck60mhz,
	input  logic               sysrsoutb,
	input  logic               baseck,		// async to ck60mhz
	input  logic               halt_sync,	// already synchronized
	input  logic               stop_sync,
	output status_pkg::count_t meter_count,	// edges in last full window
	output logic               meter_valid
);

	logic [2:0]                      bck_sync;	// 2 sync flops + edge flop
	logic                            bck_rise;
	logic [`ST_METER_WIN_LOG2-1:0]   win_cnt;
	logic                            win_end;
	status_pkg::count_t              edge_cnt;
	status_pkg::count_t              edge_next;
	status_pkg::meter_state_e        state;

	//********************
	// baseck sampling
	always_ff @(posedge ck60mhz or negedge sysrsoutb) begin
		if (!sysrsoutb)
			bck_sync <= '0;
		else
			bck_sync <= {bck_sync[1:0], baseck};
	end

	assign bck_rise = bck_sync[1] & ~bck_sync[2];

	//********************
	// window and edge count
	always_ff @(posedge ck60mhz or negedge sysrsoutb) begin
		if (!sysrsoutb)
			win_cnt <= '0;
		else
			win_cnt <= win_cnt + 1'b1;	// wraps every 2^log2 cycles
	end

	assign win_end   = &win_cnt;	// last cycle of window
	assign edge_next = edge_cnt + {{(`ST_COUNT_W-1){1'b0}}, bck_rise};

	always_ff @(posedge ck60mhz or negedge sysrsoutb) begin
		if (!sysrsoutb) begin
			edge_cnt    <= '0;
			meter_count <= '0;
		end else if (win_end) begin
			meter_count <= edge_next;	// include edge of last cycle
			edge_cnt    <= '0;
		end else begin
			edge_cnt    <= edge_next;
		end
	end

	//********************
	// valid tracking
	always_ff @(posedge ck60mhz or negedge sysrsoutb) begin
		if (!sysrsoutb)
			state <= status_pkg::meter_idle;
		else if (halt_sync || stop_sync)
			state <= status_pkg::meter_idle;	// target clock not trusted
		else if (win_end) begin
			case (state)
				status_pkg::meter_idle:  state <= status_pkg::meter_first;
				status_pkg::meter_first: state <= status_pkg::meter_valid;
				default:                 state <= status_pkg::meter_valid;
			endcase
		end
	end

	assign meter_valid = (state == status_pkg::meter_valid);

endmodule

//--- hdl/status_regs.sv
// status register block
// host decode at 0804_1000h: STATEDET, MCLKSEL (reads 0), BCKCYCLE, SYS1
// SYS1 tvddsel write register
// CPU read of meter count at 0C040h / 0C042h, LED drive

`timescale 1ns/1ps
`include "status_defs.svh"

module status_regs (
	input  logic                   ck60mhz,
	input  logic                   sysrsoutb,
	input  logic                   svmod,
	input  logic                   svmoduser,
	input  logic                   alt1,
	input  logic                   selfmode,
	input  logic                   cpuresetb,
	input  logic                   treset_b,
	input  logic                   tcconnect_b,
	input  logic                   eaconnect_b,
	input  logic                   tvddon,
	input  logic                   tbtselout,
	input  logic                   wdop,
	input  logic                   cpurd,
	input  logic [`ST_MA_W-1:0]    ma,
	input  logic [`ST_ICE_W-1:0]   ice_addr,
	input  logic [`ST_ICE_W-1:0]   ice_wdata,
	input  logic                   ice_wr,		// one cycle strobe
	input  logic                   wait_long,
	input  logic                   halt_long,
	input  logic                   stop_long,
	input  logic                   mclk_run,
	input  status_pkg::count_t     meter_count,
	input  logic                   meter_valid,
	output logic [`ST_ICE_W-1:0]   ice_rdata,
	output logic [`ST_COUNT_W-1:0] statemdr,	// CPU read data
	output logic                   tvddsel,
	output logic                   led_tvdd_b,
	output logic                   led_clock_b,
	output logic                   led_run_b,
	output logic                   led_reset_b,
	output logic                   led_standby_b,
	output logic                   led_wait_b
);

	logic                  host_hit;	// address inside register page
	status_pkg::host_reg_e reg_idx;
	logic [`ST_ICE_W-1:0]  statedet;
	logic                  cpu_sel;

	//********************
	// host decode
	assign host_hit = (ice_addr[31:12] == `ST_HOST_BASE) && (ice_addr[11:5] == '0);
	assign reg_idx  = status_pkg::host_reg_e'(ice_addr[4:2]);

	always_comb begin
		statedet     = '0;
		statedet[0]  = ~svmoduser;	// user run
		statedet[1]  = ~svmod;		// run, not in supervisor
		statedet[3]  = halt_long;
		statedet[4]  = stop_long;
		statedet[5]  = wait_long;
		statedet[6]  = tvddon;		// target vdd below range
		statedet[8]  = ~treset_b;	// target reset
		statedet[9]  = eaconnect_b;
		statedet[10] = tcconnect_b;
		statedet[15] = ~cpuresetb;
		statedet[16] = mclk_run;
		statedet[20] = selfmode;
		statedet[21] = tbtselout;	// boot swap
	end

	always_comb begin
		ice_rdata = '0;
		if (host_hit) begin
			case (reg_idx)
				status_pkg::reg_statedet: ice_rdata = statedet;
				status_pkg::reg_bckcycle: ice_rdata = {15'h0, meter_valid, meter_count};
				status_pkg::reg_sys1:     ice_rdata = {31'h0, tvddsel};
				default:                  ice_rdata = '0;	// MCLKSEL and unused words
			endcase
		end
	end

	//********************
	// SYS1 write
	always_ff @(posedge ck60mhz or negedge sysrsoutb) begin
		if (!sysrsoutb)
			tvddsel <= 1'b1;
		else if (ice_wr && host_hit && reg_idx == status_pkg::reg_sys1)
			tvddsel <= ice_wdata[0];
	end

	//********************
	// CPU read
	assign cpu_sel = svmod & ~alt1 & cpurd & wdop & (ma[15:4] == `ST_CPU_PAGE);

	always_comb begin
		statemdr = '0;
		if (cpu_sel) begin
			case (ma[3:0])
				`ST_CPU_OFS_COUNT: statemdr = meter_count;
				`ST_CPU_OFS_VALID: statemdr = {{(`ST_COUNT_W-1){1'b0}}, meter_valid};
				default:           statemdr = '0;
			endcase
		end
	end

	// LEDs, active low
	assign led_tvdd_b    = ~tvddon;
	assign led_clock_b   = mclk_run;
	assign led_run_b     = svmoduser;
	assign led_reset_b   = cpuresetb;
	assign led_standby_b = ~(stop_long | halt_long);
	assign led_wait_b    = ~wait_long;

endmodule

//--- hdl/ice_status_top.sv
// ICE status block top level
// activity monitor and clock meter feeding the register block

`timescale 1ns/1ps
`include "status_defs.svh"

module ice_status_top (
	input  logic                   ck60mhz,
	input  logic                   sysrsoutb,
	// target status
	input  logic                   waitexm,
	input  logic                   hltst,
	input  logic                   stpst,
	input  logic                   cpumclk,
	input  logic                   baseck,
	input  logic                   svmod,
	input  logic                   svmoduser,
	input  logic                   alt1,
	input  logic                   selfmode,
	input  logic                   cpuresetb,
	input  logic                   treset_b,
	input  logic                   tcconnect_b,
	input  logic                   eaconnect_b,
	input  logic                   tvddon,
	input  logic                   tbtselout,
	// CPU bus
	input  logic                   wdop,
	input  logic                   cpurd,
	input  logic [`ST_MA_W-1:0]    ma,
	output logic [`ST_COUNT_W-1:0] statemdr,
	// host bus
	input  logic [`ST_ICE_W-1:0]   ice_addr,
	input  logic [`ST_ICE_W-1:0]   ice_wdata,
	input  logic                   ice_wr,
	output logic [`ST_ICE_W-1:0]   ice_rdata,
	// pins
	output logic                   tvddsel,
	output logic                   led_tvdd_b,
	output logic                   led_clock_b,
	output logic                   led_run_b,
	output logic                   led_reset_b,
	output logic                   led_standby_b,
	output logic                   led_wait_b
);

	logic               wait_long, halt_long, stop_long, mclk_run;
	logic               halt_sync, stop_sync;
	status_pkg::count_t meter_count;
	logic               meter_valid;

	activity_monitor u_act (
		.ck60mhz, .sysrsoutb, .waitexm, .hltst, .stpst, .cpumclk,
		.wait_long, .halt_long, .stop_long, .mclk_run, .halt_sync, .stop_sync
	);

	clock_meter u_meter (
		.ck60mhz, .sysrsoutb, .baseck, .halt_sync, .stop_sync,
		.meter_count, .meter_valid
	);

	status_regs u_regs (
		.ck60mhz, .sysrsoutb, .svmod, .svmoduser, .alt1, .selfmode, .cpuresetb,
		.treset_b, .tcconnect_b, .eaconnect_b, .tvddon, .tbtselout, .wdop, .cpurd,
		.ma, .ice_addr, .ice_wdata, .ice_wr, .wait_long, .halt_long, .stop_long,
		.mclk_run, .meter_count, .meter_valid, .ice_rdata, .statemdr, .tvddsel,
		.led_tvdd_b, .led_clock_b, .led_run_b, .led_reset_b, .led_standby_b,
		.led_wait_b
	);

endmodule

//--- verif/ice_status_checker.sv
// assertion checker for the status register block
// tvddsel reset value, wait LED rule, zero read outside the host page
// bound into status_regs below

`timescale 1ns/1ps
`include "status_defs.svh"

module ice_status_checker (
	input logic                 ck60mhz,
	input logic                 sysrsoutb,
	input logic                 tvddsel,
	input logic                 led_wait_b,
	input logic                 wait_long,
	input logic [`ST_ICE_W-1:0] ice_addr,
	input logic [`ST_ICE_W-1:0] ice_rdata
);

	int err_cnt = 0;	// failed assertions so far

	//********************
	// tvddsel comes out of reset set
	a_tvddsel_rst: assert property (@(posedge ck60mhz) $rose(sysrsoutb) |-> tvddsel)
		else begin
			$error("tvddsel not set when reset released");
			err_cnt++;
		end

	// wait LED is the plain inverse of the long wait flag
	a_led_wait: assert property (@(posedge ck60mhz) disable iff (!sysrsoutb)
		led_wait_b == !wait_long)
		else begin
			$error("led_wait_b does not follow wait_long");
			err_cnt++;
		end

	// no read data outside 0804_1xxxh
	a_rdata_miss: assert property (@(posedge ck60mhz) disable iff (!sysrsoutb)
		(ice_addr[31:12] != `ST_HOST_BASE) |-> (ice_rdata == '0))
		else begin
			$error("ice_rdata not zero for address outside host page");
			err_cnt++;
		end

endmodule

bind status_regs ice_status_checker u_chk (
	.ck60mhz    (ck60mhz),
	.sysrsoutb  (sysrsoutb),
	.tvddsel    (tvddsel),
	.led_wait_b (led_wait_b),
	.wait_long  (wait_long),
	.ice_addr   (ice_addr),
	.ice_rdata  (ice_rdata)
);

//--- verif/tb_ice_status.sv
// testbench for the ICE status block
// trace commands from verif/status_trace.txt, host and CPU read checks
// background toggling of baseck / cpumclk, cycle limit

`timescale 1ns/1ps
`include "status_defs.svh"

module tb_ice_status;

	// DUT inputs
	logic                   ck60mhz, sysrsoutb;
	logic                   waitexm, hltst, stpst, cpumclk, baseck;
	logic                   svmod, svmoduser, alt1, selfmode, cpuresetb, treset_b;
	logic                   tcconnect_b, eaconnect_b, tvddon, tbtselout, wdop, cpurd;
	logic [`ST_MA_W-1:0]    ma;
	logic [`ST_ICE_W-1:0]   ice_addr, ice_wdata;
	logic                   ice_wr;
	// DUT outputs
	logic [`ST_COUNT_W-1:0] statemdr;
	logic [`ST_ICE_W-1:0]   ice_rdata;
	logic                   tvddsel, led_tvdd_b, led_clock_b, led_run_b;
	logic                   led_reset_b, led_standby_b, led_wait_b;

	// trace contents, one entry per command line
	byte                    cmd_q[$];
	logic [31:0]            f1_q[$], f2_q[$], f3_q[$], f4_q[$];
	int                     line_q[$];

	int                     cyc_cnt = 0;
	int                     cyc_limit = 0;	// 0 until trace is loaded
	int                     test_num = 0;
	int                     pass_cnt = 0;
	int                     fail_cnt = 0;
	int                     gen_id [2];		// 0 baseck, 1 cpumclk

	ice_status_top dut (.*);

	always #10 ck60mhz = ~ck60mhz;	// 50 MHz in sim, period only matters relative

	//********************
	// cycle limit
	always @(posedge ck60mhz) begin
		cyc_cnt <= cyc_cnt + 1;
		if (cyc_limit != 0 && cyc_cnt > cyc_limit) begin
			$display("timeout: run went past %0d clock cycles", cyc_limit);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic init_inputs();
		ck60mhz   = 1'b0;
		sysrsoutb = 1'b0;
		{waitexm, hltst, stpst, cpumclk, baseck} = '0;
		{svmod, svmoduser, alt1, selfmode, cpuresetb, treset_b} = '0;
		{tcconnect_b, eaconnect_b, tvddon, tbtselout, wdop, cpurd} = '0;
		ma        = '0;
		ice_addr  = '0;
		ice_wdata = '0;
		ice_wr    = 1'b0;
		gen_id[0] = 0;
		gen_id[1] = 0;
	endtask

	// read trace into queues, limit = idle cycles + access cost + margin
	task automatic load_trace(output bit ok);
		int          fd;
		int          ln;
		string       line;
		byte         c;
		logic [31:0] a, b, d, e;
		ok = 0;
		ln = 0;
		fd = $fopen("verif/status_trace.txt", "r");
		if (fd != 0) begin
			ok = 1;
			cyc_limit = 3 + 500;
			while ($fgets(line, fd) != 0) begin
				ln++;
				c = line[0];
				if (line.len() > 1 && c != "#" && c != " ") begin
					a = '0;
					b = '0;
					d = '0;
					e = '0;
					void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a, b, d, e));
					cmd_q.push_back(c);
					f1_q.push_back(a);
					f2_q.push_back(b);
					f3_q.push_back(d);
					f4_q.push_back(e);
					line_q.push_back(ln);
					case (c)
						"I":           cyc_limit += a;
						"R", "W", "C": cyc_limit += 4;	// gap + access
						default:       cyc_limit += 1;
					endcase
				end
			end
			$fclose(fd);
		end
	endtask

	//********************
	// stimulus helpers
	task automatic apply_levels(input logic [31:0] lv);
		@(negedge ck60mhz);
		waitexm     = lv[0];
		hltst       = lv[1];
		stpst       = lv[2];
		svmod       = lv[3];
		svmoduser   = lv[4];
		alt1        = lv[5];
		selfmode    = lv[6];
		cpuresetb   = lv[7];
		treset_b    = lv[8];
		tcconnect_b = lv[9];
		eaconnect_b = lv[10];
		tvddon      = lv[11];
		tbtselout   = lv[12];
		wdop        = lv[13];
		cpurd       = lv[14];
	endtask

	// toggles every half falling edges while its id is current
	task automatic toggle_clock(input int sel, input int half, input int len, input int id);
		int ph;
		ph = 0;
		for (int i = 0; i < len && gen_id[sel] == id; i++) begin
			@(negedge ck60mhz);
			ph++;
			if (ph == half && gen_id[sel] == id) begin
				ph = 0;
				if (sel == 0)
					baseck = ~baseck;
				else
					cpumclk = ~cpumclk;
			end
		end
	endtask

	task automatic start_toggle(input int sel, input int half, input int len);
		int id;
		gen_id[sel]++;	// stops any running generator
		id = gen_id[sel];
		if (half != 0) begin
			fork
				toggle_clock(sel, half, len, id);
			join_none
		end
	endtask

	task automatic host_write(input logic [31:0] addr, input logic [31:0] data);
		@(negedge ck60mhz);
		ice_addr  = addr;
		ice_wdata = data;
		ice_wr    = 1'b1;
		@(negedge ck60mhz);
		ice_wr    = 1'b0;
	endtask

	//********************
	// checks
	task automatic report_test(input bit ok, input string what, input int ln);
		test_num++;
		if (ok) begin
			pass_cnt++;
			$display("test %0d, %s, trace line %0d: pass", test_num, what, ln);
		end else begin
			fail_cnt++;
			$display("test %0d, %s, trace line %0d: FAIL", test_num, what, ln);
		end
	endtask

	task automatic host_read_check(input logic [31:0] addr, exp, pexp, pmask, input int ln);
		logic [31:0] got;
		logic [6:0]  pins;
		bit          ok;
		repeat ($urandom % 3) @(negedge ck60mhz);
		@(negedge ck60mhz);
		ice_addr = addr;
		@(negedge ck60mhz);
		got  = ice_rdata;
		pins = {tvddsel, led_tvdd_b, led_clock_b, led_run_b, led_reset_b,
			led_standby_b, led_wait_b};
		ok = 1;
		if (got !== exp) begin
			$display("MISMATCH at %0t: host read %h gave %h, expected %h", $time, addr, got, exp);
			ok = 0;
		end
		if ((pins & pmask[6:0]) !== (pexp[6:0] & pmask[6:0])) begin
			$display("MISMATCH at %0t: pins %b, expected %b under mask %b", $time, pins,
				pexp[6:0], pmask[6:0]);
			ok = 0;
		end
		report_test(ok, "host read", ln);
	endtask

	task automatic cpu_read_check(input logic [31:0] addr, exp, tol, input int ln);
		logic [`ST_COUNT_W-1:0] got;
		int                     diff;
		bit                     ok;
		repeat ($urandom % 3) @(negedge ck60mhz);
		@(negedge ck60mhz);
		ma = addr[`ST_MA_W-1:0];
		@(negedge ck60mhz);
		got  = statemdr;
		diff = int'(got) - int'(exp);
		if (diff < 0)
			diff = -diff;
		ok = 1;
		if (diff > int'(tol)) begin
			$display("MISMATCH at %0t: cpu read %h gave %h, expected %h +-%0d", $time,
				addr[15:0], got, exp[15:0], tol);
			ok = 0;
		end
		report_test(ok, "cpu read", ln);
	endtask

	task automatic run_trace();
		bit done;
		done = 0;
		for (int k = 0; k < cmd_q.size() && !done; k++) begin
			case (cmd_q[k])
				"L": apply_levels(f1_q[k]);
				"B": start_toggle(0, f1_q[k], f2_q[k]);
				"M": start_toggle(1, f1_q[k], f2_q[k]);
				"I": repeat (f1_q[k]) @(negedge ck60mhz);
				"W": host_write(f1_q[k], f2_q[k]);
				"R": host_read_check(f1_q[k], f2_q[k], f3_q[k], f4_q[k], line_q[k]);
				"C": cpu_read_check(f1_q[k], f2_q[k], f3_q[k], line_q[k]);
				"E": done = 1;
				default: begin
					$display("trace line %0d has an unknown command", line_q[k]);
					fail_cnt++;
				end
			endcase
		end
	endtask

	//********************
	// main sequence
	initial begin
		bit ok;
		int chk_err;
		void'($urandom(32'hc6e6));
		init_inputs();
		load_trace(ok);
		if (!ok) begin
			$display("could not open trace file verif/status_trace.txt");
			fail_cnt++;
		end else begin
			repeat (3) @(negedge ck60mhz);	// reset for 3 cycles
			sysrsoutb = 1'b1;
			run_trace();
		end
		chk_err = dut.u_regs.u_chk.err_cnt;
		$display("tests %0d, passed %0d, failed %0d, assertion errors %0d", test_num,
			pass_cnt, fail_cnt, chk_err);
		if (fail_cnt == 0 && chk_err == 0 && test_num > 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- verif/status_trace.txt
# one command per line, fields hex: L lvl | B half len | M half len | I cyc | W addr data
# R addr data pins pinmask | C ma data tol | E    (B/M half 0 stops the generator)
# lvl bits 0..14: waitexm hltst stpst svmod svmoduser alt1 selfmode cpuresetb
#   treset_b tcconnect_b eaconnect_b tvddon tbtselout wdop cpurd
# pins bits 6..0: tvddsel led_tvdd_b led_clock_b led_run_b led_reset_b led_standby_b led_wait_b
# after reset
L 6198
R 0804100c 00000001 40 40
R 08041008 00000000 00 00
W 0804100c 00000000
R 0804100c 00000000 00 40
R 08041004 00000000 00 00
R 08042000 00000000 00 00
R 08041020 00000000 00 00
# static levels into STATEDET and LEDs
L 7e48
I 2
R 08041000 00308741 03 7f
L 0190
I 2
R 08041000 00000002 2f 7f
# hold timers, wait / halt / stop
L 6199
I 4a
R 08041000 00000020 2e 7f
L 6198
I a
R 08041000 00000000 2f 7f
L 619a
I 4a
R 08041000 00000008 2d 7f
L 6198
I a
R 08041000 00000000 2f 7f
L 619c
I 4a
R 08041000 00000010 2d 7f
L 6198
I a
R 08041000 00000000 2f 7f
# main clock run / stop
M 2 ffff
I a
R 08041000 00010000 3f 7f
M 0 0
I 2a
R 08041000 00000000 2f 7f
# meter, baseck period 8 clocks -> 32 per window
B 4 ffff
I 320
R 08041008 00010020 2f 7f
C c040 0020 1
C c042 0001 0
L 61b8
C c040 0000 0
L 4198
C c040 0000 0
L 6198
# halt drops valid, count kept
L 619a
I 4
R 08041008 00000020 00 00
B 0 0
E

//--- flist.f
+incdir+include
hdl/status_pkg.sv
hdl/activity_monitor.sv
hdl/clock_meter.sv
hdl/status_regs.sv
hdl/ice_status_top.sv
verif/ice_status_checker.sv
verif/tb_ice_status.sv

//--- Makefile
# Verilator build and run of the ICE status block testbench

VERILATOR ?= verilator
TOP       ?= tb_ice_status
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
ERR_LIMIT ?= 100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, search $(LOG) for failure"
	@echo "  clean  remove build directory and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERR_LIMIT) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "no result in $(LOG)"; exit 1; fi
	@echo "simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
